//--- hdl/mbx_consts.svh
`ifndef MBX_CONSTS_SVH
`define MBX_CONSTS_SVH

// Words per cache line, one MB slot per word
`define MBX_WORDS 4

// Width of an MB slot index, same as the low physical address bits
`define MBX_SEL_BITS 2

`endif

//--- hdl/mbxPkg.sv
`include "mbx_consts.svh"

package mbxPkg;

  typedef logic [`MBX_WORDS-1:0] wordMask_t;
  typedef logic [`MBX_SEL_BITS-1:0] wordSel_t;

  // Cache to MB writeback sequencer
  typedef enum logic [2:0] {idle, outEn, t1, t2, t3, t4} c2mbState_e;

  // Priority encoder, slot 0 has the highest priority
  function automatic wordSel_t lowestSlot(wordMask_t mask);
    wordSel_t slot;
    slot = '0;
    for (int i = `MBX_WORDS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        slot = wordSel_t'(i);
      end
    end
    return slot;
  endfunction

endpackage

//--- hdl/mbReqIf.sv
`timescale 1ns/1ps

interface mbReqIf (input logic clk);

  // Per-slot MB write request bits
  mbxPkg::wordMask_t pending;

  // Sequencer load strobe
  logic              loadWord;
  mbxPkg::wordSel_t  loadSel;

  // Arbiter grant and release
  logic              clear;
  mbxPkg::wordSel_t  sel;

  modport tracker (input clk, output pending, input loadWord, input loadSel,
                   input clear, input sel);

  modport sequencer (input clk, output loadWord, output loadSel);

  modport arbiter (input clk, output clear, output sel, input pending);

  modport monitor (input clk, input pending);

endinterface

//--- hdl/requestDecoder.sv
`timescale 1ns/1ps
`include "mbx_consts.svh"

module requestDecoder (
  input  logic              clk,
  input  logic              reset,
  input  logic              coreRdRq,
  input  logic              oneWordRd,
  input  mbxPkg::wordSel_t  paLow,
  input  mbxPkg::wordMask_t wordVal,
  input  logic              writebackBusy,
  output mbxPkg::wordMask_t rqIn,
  output logic              memRdRqIn,
  mbReqIf.monitor           req
);

  logic              rdRqDly;
  logic              rdRqFirst;
  logic              lineRdNonVal;
  mbxPkg::wordMask_t valHold;
  mbxPkg::wordMask_t valUsed;

  ////////////////////////////////////////////////////////////
  // Word valid hold for line reads
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rdRqDly <= 1'b0;
    end else begin
      rdRqDly <= coreRdRq;
    end
  end

  assign rdRqFirst = coreRdRq & ~rdRqDly;

  // Cache valid bits may change once the refill starts
  always_ff @(posedge clk) begin
    if (rdRqFirst) begin
      valHold <= wordVal;
    end
  end

  // First cycle sees the live mask, later cycles the held one
  assign valUsed = rdRqFirst ? wordVal : valHold;

  ////////////////////////////////////////////////////////////
  // Per-word request vector
  ////////////////////////////////////////////////////////////

  assign lineRdNonVal = coreRdRq & ~oneWordRd;

  always_comb begin
    for (int i = 0; i < `MBX_WORDS; i++) begin
      rqIn[i] = (oneWordRd && paLow == mbxPkg::wordSel_t'(i)) ||
                (writebackBusy && req.pending[i]) ||
                (lineRdNonVal && !valUsed[i]);
    end
  end

  assign memRdRqIn = coreRdRq | oneWordRd;

endmodule

//--- hdl/cacheToMbSequencer.sv
`timescale 1ns/1ps

module cacheToMbSequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              writebackStart,
  input  mbxPkg::wordMask_t wordVal,
  input  logic              phaseChangeComing,
  output logic              cacheToMbDone,
  output logic              memWrRqIn,
  output logic              writebackBusy,
  mbReqIf.sequencer         req
);

  mbxPkg::c2mbState_e state;
  mbxPkg::c2mbState_e stateNext;
  mbxPkg::wordMask_t  remain;
  mbxPkg::wordMask_t  remainNext;
  mbxPkg::wordSel_t   nextWord;
  logic               anyLeft;

  ////////////////////////////////////////////////////////////
  // Word selection
  ////////////////////////////////////////////////////////////

  assign nextWord = mbxPkg::lowestSlot(remain);
  assign anyLeft = |remain;

  always_comb begin
    remainNext = remain;
    if (state == mbxPkg::idle && writebackStart) begin
      remainNext = wordVal;
    end else if (state == mbxPkg::t3) begin
      remainNext[nextWord] = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // T1 to T4 state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      mbxPkg::idle: begin
        if (writebackStart) begin
          stateNext = mbxPkg::outEn;
        end
      end
      mbxPkg::outEn: stateNext = mbxPkg::t1;
      mbxPkg::t1:    stateNext = anyLeft ? mbxPkg::t2 : mbxPkg::idle;
      // Hold off until memory is about to change phase
      mbxPkg::t2: begin
        if (phaseChangeComing) begin
          stateNext = mbxPkg::t3;
        end
      end
      mbxPkg::t3:    stateNext = mbxPkg::t4;
      mbxPkg::t4:    stateNext = mbxPkg::t1;
      default:       stateNext = mbxPkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= mbxPkg::idle;
      remain <= '0;
    end else begin
      state  <= stateNext;
      remain <= remainNext;
    end
  end

  assign req.loadWord  = (state == mbxPkg::t3);
  assign req.loadSel   = nextWord;
  assign cacheToMbDone = (state == mbxPkg::t1) && !anyLeft;
  assign memWrRqIn     = (state == mbxPkg::t4);
  assign writebackBusy = (state != mbxPkg::idle);

  // A load only happens in t3 and takes a word still in the captured mask
  loadInT3: assert property (@(posedge clk) disable iff (reset)
    req.loadWord |-> (state == mbxPkg::t3 && remain[req.loadSel]))
    else $error("loadWord outside of t3 or for a word already moved");

endmodule

//--- hdl/mbWordTracker.sv
`timescale 1ns/1ps
`include "mbx_consts.svh"

module mbWordTracker (
  input  logic             clk,
  input  logic             reset,
  input  logic             coreWordComing,
  input  mbxPkg::wordSel_t coreWordAdr,
  mbReqIf.tracker          req
);

  mbxPkg::wordMask_t setMask;
  mbxPkg::wordMask_t clrMask;
  mbxPkg::wordMask_t pendingNext;

  ////////////////////////////////////////////////////////////
  // Slot decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `MBX_WORDS; i++) begin
      setMask[i] = (req.loadWord && req.loadSel == mbxPkg::wordSel_t'(i)) ||
                   (coreWordComing && coreWordAdr == mbxPkg::wordSel_t'(i));
      clrMask[i] = req.clear && req.sel == mbxPkg::wordSel_t'(i);
    end
  end

  // Set wins over clear on the same slot
  assign pendingNext = (req.pending & ~clrMask) | setMask;

  ////////////////////////////////////////////////////////////
  // Request flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      req.pending <= '0;
    end else begin
      req.pending <= pendingNext;
    end
  end

  // The arbiter only releases a slot it saw pending
  clearOnPending: assert property (@(posedge clk) disable iff (reset)
    req.clear |-> req.pending[req.sel])
    else $error("clear for slot %0d which is not pending", req.sel);

endmodule

//--- hdl/mbSelectArbiter.sv
`timescale 1ns/1ps

module mbSelectArbiter (
  input  logic    clk,
  input  logic    reset,
  input  logic    acknPulse,
  output logic    mbReqHold,
  mbReqIf.arbiter req
);

  logic anyPending;

  assign anyPending = |req.pending;

  ////////////////////////////////////////////////////////////
  // Grant and hold
  ////////////////////////////////////////////////////////////

  // Sel tracks the lowest pending slot until the request is held,
  // then stays frozen up to the acknowledge
  always_ff @(posedge clk) begin
    if (reset) begin
      mbReqHold <= 1'b0;
      req.sel   <= '0;
    end else if (!mbReqHold) begin
      mbReqHold <= anyPending;
      req.sel   <= mbxPkg::lowestSlot(req.pending);
    end else if (acknPulse) begin
      mbReqHold <= 1'b0;
    end
  end

  // Stray acks are dropped
  assign req.clear = acknPulse & mbReqHold;

  grantIsPending: assert property (@(posedge clk) disable iff (reset)
    mbReqHold |-> req.pending[req.sel])
    else $error("MB request held for slot %0d with no pending word", req.sel);

endmodule

//--- hdl/mbxTop.sv
`timescale 1ns/1ps

module mbxTop (
  input  logic              clk,
  input  logic              reset,
  input  logic              writebackStart,
  input  mbxPkg::wordMask_t wordVal,
  input  logic              coreRdRq,
  input  logic              oneWordRd,
  input  mbxPkg::wordSel_t  paLow,
  input  logic              phaseChangeComing,
  input  logic              coreWordComing,
  input  mbxPkg::wordSel_t  coreWordAdr,
  input  logic              acknPulse,
  output mbxPkg::wordSel_t  mbSel,
  output logic              mbReqHold,
  output mbxPkg::wordMask_t rqIn,
  output logic              memRdRqIn,
  output logic              memWrRqIn,
  output logic              cacheToMbDone,
  output logic              writebackBusy
);

  mbReqIf req (.clk(clk));

  ////////////////////////////////////////////////////////////
  // Slot request sources
  ////////////////////////////////////////////////////////////

  cacheToMbSequencer sequencer (
    .clk              (clk),
    .reset            (reset),
    .writebackStart   (writebackStart),
    .wordVal          (wordVal),
    .phaseChangeComing(phaseChangeComing),
    .cacheToMbDone    (cacheToMbDone),
    .memWrRqIn        (memWrRqIn),
    .writebackBusy    (writebackBusy),
    .req              (req.sequencer)
  );

  mbWordTracker tracker (
    .clk           (clk),
    .reset         (reset),
    .coreWordComing(coreWordComing),
    .coreWordAdr   (coreWordAdr),
    .req           (req.tracker)
  );

  ////////////////////////////////////////////////////////////
  // Memory bus side
  ////////////////////////////////////////////////////////////

  mbSelectArbiter arbiter (
    .clk      (clk),
    .reset    (reset),
    .acknPulse(acknPulse),
    .mbReqHold(mbReqHold),
    .req      (req.arbiter)
  );

  requestDecoder decoder (
    .clk          (clk),
    .reset        (reset),
    .coreRdRq     (coreRdRq),
    .oneWordRd    (oneWordRd),
    .paLow        (paLow),
    .wordVal      (wordVal),
    .writebackBusy(writebackBusy),
    .rqIn         (rqIn),
    .memRdRqIn    (memRdRqIn),
    .req          (req.monitor)
  );

  assign mbSel = req.sel;

endmodule

//--- verif/mbxTests.svh
`ifndef MBX_TESTS_SVH
`define MBX_TESTS_SVH

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

// Inputs change 1 ns after the rising edge
task automatic tick();
  @(posedge clk);
  #1;
endtask

task automatic checkVal(string testName, string what, int expected, int actual);
  assert (actual == expected)
  else failRun($sformatf("[FAIL] %s: %s expected 0x%0h, actual 0x%0h",
                         testName, what, expected, actual));
endtask

// Reference for the lowest-first grant order
function automatic mbxPkg::wordSel_t lowestOf(mbxPkg::wordMask_t mask);
  for (int i = 0; i < `MBX_WORDS; i++) begin
    if (mask[i]) return mbxPkg::wordSel_t'(i);
  end
  return '0;
endfunction

function automatic int countOnes(mbxPkg::wordMask_t mask);
  int n;
  n = 0;
  for (int i = 0; i < `MBX_WORDS; i++) begin
    n += int'(mask[i]);
  end
  return n;
endfunction

task automatic pulseCoreWord(int adr);
  coreWordComing = 1'b1;
  coreWordAdr    = mbxPkg::wordSel_t'(adr);
  tick();
  coreWordComing = 1'b0;
endtask

task automatic waitHold();
  while (!mbReqHold) tick();
endtask

// Ack each grant and expect the lowest slot still outstanding
task automatic serviceGrants(string testName, mbxPkg::wordMask_t expected);
  mbxPkg::wordSel_t slot;
  while (expected != '0) begin
    waitHold();
    slot = lowestOf(expected);
    checkVal(testName, "mbSel", int'(slot), int'(mbSel));
    acknPulse = 1'b1;
    tick();
    acknPulse = 1'b0;
    expected[slot] = 1'b0;
  end
  checkVal(testName, "mbReqHold", 0, int'(mbReqHold));
  tick();
  checkVal(testName, "mbReqHold", 0, int'(mbReqHold));
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic testReset();
  string name = "reset";
  checkVal(name, "mbReqHold", 0, int'(mbReqHold));
  checkVal(name, "cacheToMbDone", 0, int'(cacheToMbDone));
  checkVal(name, "memWrRqIn", 0, int'(memWrRqIn));
  checkVal(name, "writebackBusy", 0, int'(writebackBusy));
endtask

task automatic testEmptyWriteback();
  string name = "emptyWriteback";
  writebackStart = 1'b1;
  wordVal        = '0;
  tick();
  writebackStart = 1'b0;
  checkVal(name, "cacheToMbDone", 0, int'(cacheToMbDone));
  checkVal(name, "writebackBusy", 1, int'(writebackBusy));
  tick();
  checkVal(name, "cacheToMbDone", 1, int'(cacheToMbDone));
  tick();
  checkVal(name, "cacheToMbDone", 0, int'(cacheToMbDone));
  checkVal(name, "writebackBusy", 0, int'(writebackBusy));
  checkVal(name, "mbReqHold", 0, int'(mbReqHold));
endtask

task automatic testRandomWriteback();
  string             name = "randomWriteback";
  mbxPkg::wordMask_t mask;
  int                writes;
  mask   = '0;
  writes = 0;
  while (mask == '0) mask = mbxPkg::wordMask_t'($random(seed));
  writebackStart    = 1'b1;
  wordVal           = mask;
  phaseChangeComing = 1'b1;
  tick();
  writebackStart = 1'b0;
  // One t4 cycle per valid word
  while (!cacheToMbDone) begin
    if (memWrRqIn) writes++;
    tick();
  end
  phaseChangeComing = 1'b0;
  checkVal(name, "memWrRqIn cycles", countOnes(mask), writes);
  // Every moved word is still pending and requested while the writeback is busy
  checkVal(name, "rqIn writeback", int'(mask), int'(rqIn));
  tick();
  checkVal(name, "writebackBusy", 0, int'(writebackBusy));
  checkVal(name, "rqIn after writeback", 0, int'(rqIn));
  serviceGrants(name, mask);
endtask

task automatic testCoreWords();
  string name = "coreWords";
  pulseCoreWord(0);
  waitHold();
  checkVal(name, "mbSel", 0, int'(mbSel));
  // Slot 0 keeps the bus while the others arrive out of order
  pulseCoreWord(3);
  pulseCoreWord(1);
  pulseCoreWord(2);
  serviceGrants(name, 4'b1111);
endtask

task automatic testRequestDecode();
  string             name = "requestDecode";
  mbxPkg::wordMask_t mask;
  mbxPkg::wordMask_t missing;
  oneWordRd = 1'b1;
  coreRdRq  = 1'b0;
  for (int a = 0; a < `MBX_WORDS; a++) begin
    paLow = mbxPkg::wordSel_t'(a);
    #1;
    checkVal(name, "rqIn one word", 1 << a, int'(rqIn));
    checkVal(name, "memRdRqIn", 1, int'(memRdRqIn));
    tick();
  end
  mask      = mbxPkg::wordMask_t'($random(seed));
  missing   = ~mask;
  oneWordRd = 1'b0;
  coreRdRq  = 1'b1;
  wordVal   = mask;
  #1;
  checkVal(name, "rqIn line read", int'(missing), int'(rqIn));
  checkVal(name, "memRdRqIn", 1, int'(memRdRqIn));
  tick();
  // Valid bits move on, the held mask from the first cycle still counts
  wordVal = ~mask;
  #1;
  checkVal(name, "rqIn held mask", int'(missing), int'(rqIn));
  tick();
  coreRdRq = 1'b0;
  wordVal  = '0;
  #1;
  checkVal(name, "rqIn idle", 0, int'(rqIn));
  checkVal(name, "memRdRqIn", 0, int'(memRdRqIn));
  tick();
endtask

task automatic testStrayAck();
  string name = "strayAck";
  checkVal(name, "mbReqHold", 0, int'(mbReqHold));
  acknPulse = 1'b1;
  tick();
  acknPulse = 1'b0;
  checkVal(name, "mbReqHold", 0, int'(mbReqHold));
  tick();
  checkVal(name, "mbReqHold", 0, int'(mbReqHold));
  pulseCoreWord(2);
  serviceGrants(name, 4'b0100);
endtask

`endif

//--- verif/tbMbx.sv
`timescale 1ns/1ps
`include "mbx_consts.svh"

module tbMbx;

  // The longest test runs well under 100 cycles, so this leaves a wide margin
  localparam int MaxCycles = 2000;

  logic              clk;
  logic              reset;
  logic              writebackStart;
  mbxPkg::wordMask_t wordVal;
  logic              coreRdRq;
  logic              oneWordRd;
  mbxPkg::wordSel_t  paLow;
  logic              phaseChangeComing;
  logic              coreWordComing;
  mbxPkg::wordSel_t  coreWordAdr;
  logic              acknPulse;
  mbxPkg::wordSel_t  mbSel;
  logic              mbReqHold;
  mbxPkg::wordMask_t rqIn;
  logic              memRdRqIn;
  logic              memWrRqIn;
  logic              cacheToMbDone;
  logic              writebackBusy;

  int cycleCount = 0;
  int seed;

  mbxTop dut (
    .clk              (clk),
    .reset            (reset),
    .writebackStart   (writebackStart),
    .wordVal          (wordVal),
    .coreRdRq         (coreRdRq),
    .oneWordRd        (oneWordRd),
    .paLow            (paLow),
    .phaseChangeComing(phaseChangeComing),
    .coreWordComing   (coreWordComing),
    .coreWordAdr      (coreWordAdr),
    .acknPulse        (acknPulse),
    .mbSel            (mbSel),
    .mbReqHold        (mbReqHold),
    .rqIn             (rqIn),
    .memRdRqIn        (memRdRqIn),
    .memWrRqIn        (memWrRqIn),
    .cacheToMbDone    (cacheToMbDone),
    .writebackBusy    (writebackBusy)
  );

  task automatic failRun(string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "mbxTests.svh"

  ////////////////////////////////////////////////////////////
  // Clock and cycle limit
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > MaxCycles) begin
      failRun($sformatf("Timeout: the tests did not finish within %0d cycles", MaxCycles));
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed              = 635;
    reset             = 1'b1;
    writebackStart    = 1'b0;
    wordVal           = '0;
    coreRdRq          = 1'b0;
    oneWordRd         = 1'b0;
    paLow             = '0;
    phaseChangeComing = 1'b0;
    coreWordComing    = 1'b0;
    coreWordAdr       = '0;
    acknPulse         = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    testReset();
    testEmptyWriteback();
    testRandomWriteback();
    testCoreWords();
    testRequestDecode();
    testStrayAck();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
+incdir+verif
hdl/mbxPkg.sv
hdl/mbReqIf.sv
hdl/requestDecoder.sv
hdl/cacheToMbSequencer.sv
hdl/mbWordTracker.sv
hdl/mbSelectArbiter.sv
hdl/mbxTop.sv
verif/tbMbx.sv

//--- Makefile
TOP = tbMbx
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || \
		{ echo "Simulation ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
